// ==== verilog/turf_link_pkg.sv ====
package turf_link_pkg;

    // One CIN or COUT symbol
    // Bit 3 goes on the wire first
    typedef logic [3:0] nybble_t;

    // One full link word, carried as eight nybbles
    typedef logic [31:0] word_t;

    // Nybble slot inside an 8-cycle frame
    typedef logic [2:0] frame_phase_t;

    // Nybbles that make up one word
    localparam int unsigned NYBBLES_PER_WORD = $bits(word_t) / $bits(nybble_t);

    // Phase that carries the last nybble of a word
    localparam frame_phase_t FRAME_LAST = frame_phase_t'(NYBBLES_PER_WORD - 1);

    // Idle pattern sent in both directions while there is no traffic
    // No rotation of it by 1 to 3 bits equals itself, so alignment is unique
    localparam word_t DEFAULT_TRAIN_SEQUENCE = 32'hA55A6996;

endpackage

// ==== verilog/turf_cmd_pkg.sv ====
package turf_cmd_pkg;

    // Register file address, eight entries
    typedef logic [2:0] reg_index_t;

    // Register payload
    typedef logic [23:0] reg_data_t;

    // Number of registers behind the executor
    localparam int unsigned NUM_REGS = 2 ** $bits(reg_index_t);

    // Command word as it arrives on CIN
    typedef struct packed {
        logic       write;
        logic [3:0] rsvd;
        reg_index_t index;
        reg_data_t  data;
    } cmd_t;

    // Response word as it leaves on COUT
    // Tag byte is write, four zeros, index, so it tops out at 87h
    // and can never look like the A5h leading byte of training
    typedef struct packed {
        logic       write;
        logic [3:0] zero;
        reg_index_t index;
        reg_data_t  data;
    } resp_t;

endpackage

// ==== verilog/turf_cin_sync.sv ====
module turf_cin_sync #(
    parameter turf_link_pkg::word_t TRAIN_SEQUENCE = turf_link_pkg::DEFAULT_TRAIN_SEQUENCE,
    parameter int unsigned          LOCK_COUNT     = 4,
    parameter int unsigned          FIFO_DEPTH     = 4
) (
    input  logic                   sysclk_i,
    input  logic                   reset_i,
    input  turf_link_pkg::nybble_t cin_i,
    input  logic                   credit_return_i,
    output logic                   cmd_push_o,
    output turf_cmd_pkg::cmd_t     cmd_o,
    output logic                   locked_o,
    output logic                   overflow_o
);

    import turf_link_pkg::*;
    import turf_cmd_pkg::*;

    localparam int unsigned NYB_W   = $bits(nybble_t);
    localparam int unsigned WORD_W  = $bits(word_t);
    // A word may end on any of the four bits of a nybble
    localparam int unsigned HIST_W  = WORD_W + NYB_W - 1;
    localparam int unsigned ALIGN_W = $clog2(NYB_W);
    localparam int unsigned CNT_W   = $clog2(LOCK_COUNT + 1);
    localparam int unsigned CRED_W  = $clog2(FIFO_DEPTH + 1);

    typedef enum logic [1:0] {
        S_HUNT,
        S_CHECK,
        S_LOCKED
    } sync_state_t;

    sync_state_t             state_q;
    // Older bits, the current nybble completes the history
    logic [HIST_W-NYB_W-1:0] hist_q;
    logic [HIST_W-1:0]       bit_hist;
    logic [NYB_W-1:0]        win_match;
    logic [ALIGN_W-1:0]      hunt_align;
    logic [ALIGN_W-1:0]      align_q;
    frame_phase_t            phase_q;
    logic [CNT_W-1:0]        match_cnt_q;
    logic [CRED_W-1:0]       credit_q;
    word_t                   cur_word;
    logic                    word_is_train;
    logic                    boundary;
    logic                    push_now;
    logic                    drop_now;

    // Newest bit sits at index 0
    assign bit_hist = {hist_q, cin_i};

    // Compare every candidate window against training in each cycle
    // and pick the lowest matching offset while hunting
    always_comb begin
        hunt_align = '0;
        for (int k = 0; k < NYB_W; k++) begin
            win_match[k] = (bit_hist[k +: WORD_W] == TRAIN_SEQUENCE);
        end
        for (int k = NYB_W - 1; k >= 0; k--) begin
            if (win_match[k]) begin
                hunt_align = ALIGN_W'(k);
            end
        end
    end

    // Word on the chosen alignment
    assign cur_word      = bit_hist[align_q +: WORD_W];
    assign word_is_train = win_match[align_q];
    // Cycle where the 8th nybble of a framed word is sampled
    assign boundary      = (phase_q == FRAME_LAST);

    // Only non-training words become commands once locked
    assign push_now = (state_q == S_LOCKED) && boundary && !word_is_train && (credit_q != '0);
    assign drop_now = (state_q == S_LOCKED) && boundary && !word_is_train && (credit_q == '0);

    assign locked_o = (state_q == S_LOCKED);

    // Bit history and command payload
    always_ff @(posedge sysclk_i) begin
        hist_q <= bit_hist[HIST_W-NYB_W-1:0];
        if (push_now) begin
            cmd_o <= cmd_t'(cur_word);
        end
    end

    always_ff @(posedge sysclk_i) begin
        if (reset_i) begin
            state_q     <= S_HUNT;
            align_q     <= '0;
            phase_q     <= '0;
            match_cnt_q <= '0;
            credit_q    <= CRED_W'(FIFO_DEPTH);
            cmd_push_o  <= 1'b0;
            overflow_o  <= 1'b0;
        end else begin
            phase_q    <= phase_q + 1'b1;
            cmd_push_o <= push_now;
            // Sticky until reset
            if (drop_now) begin
                overflow_o <= 1'b1;
            end
            // Push and return in one cycle cancel out
            credit_q <= credit_q + CRED_W'(credit_return_i) - CRED_W'(push_now);
            case (state_q)
                S_HUNT: begin
                    if (|win_match) begin
                        // Restart the word boundary on this match
                        align_q     <= hunt_align;
                        phase_q     <= '0;
                        match_cnt_q <= CNT_W'(1);
                        state_q     <= (LOCK_COUNT <= 1) ? S_LOCKED : S_CHECK;
                    end
                end
                S_CHECK: begin
                    if (boundary) begin
                        if (word_is_train) begin
                            match_cnt_q <= match_cnt_q + 1'b1;
                            if (match_cnt_q + 1'b1 == CNT_W'(LOCK_COUNT)) begin
                                state_q <= S_LOCKED;
                            end
                        end else begin
                            // Any miss before lock starts the search over
                            state_q <= S_HUNT;
                        end
                    end
                end
                // Held until reset
                default: state_q <= S_LOCKED;
            endcase
        end
    end

    // Credits come back from the buffer, so they must never outnumber its slots
    a_credit_bound: assert property (
        @(posedge sysclk_i) disable iff (reset_i)
        credit_q <= CRED_W'(FIFO_DEPTH)
    ) else $error("cin_sync credit counter above FIFO_DEPTH");

endmodule

// ==== verilog/turf_cmd_fifo.sv ====
module turf_cmd_fifo #(
    parameter int unsigned FIFO_DEPTH = 4
) (
    input  logic               sysclk_i,
    input  logic               reset_i,
    input  logic               cmd_push_i,
    input  turf_cmd_pkg::cmd_t cmd_i,
    input  logic               cmd_pop_i,
    output logic               cmd_valid_o,
    output turf_cmd_pkg::cmd_t cmd_o,
    output logic               credit_return_o
);

    import turf_cmd_pkg::*;

    localparam int unsigned PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int unsigned CNT_W = $clog2(FIFO_DEPTH + 1);

    cmd_t             mem_q [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             do_pop;

    // Wrap at FIFO_DEPTH, which need not be a power of two
    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    // Show-ahead head, valid whenever something is stored
    assign cmd_valid_o = (count_q != '0);
    assign cmd_o       = mem_q[rd_ptr_q];
    assign do_pop      = cmd_pop_i && cmd_valid_o;

    // Storage
    always_ff @(posedge sysclk_i) begin
        if (cmd_push_i) begin
            mem_q[wr_ptr_q] <= cmd_i;
        end
    end

    always_ff @(posedge sysclk_i) begin
        if (reset_i) begin
            wr_ptr_q        <= '0;
            rd_ptr_q        <= '0;
            count_q         <= '0;
            credit_return_o <= 1'b0;
        end else begin
            if (cmd_push_i) begin
                wr_ptr_q <= ptr_next(wr_ptr_q);
            end
            if (do_pop) begin
                rd_ptr_q <= ptr_next(rd_ptr_q);
            end
            count_q         <= count_q + CNT_W'(cmd_push_i) - CNT_W'(do_pop);
            // One credit back to the receiver per freed slot
            credit_return_o <= do_pop;
        end
    end

    // Receiver credit accounting must keep a full buffer from seeing a push
    a_no_push_full: assert property (
        @(posedge sysclk_i) disable iff (reset_i)
        cmd_push_i |-> (count_q < CNT_W'(FIFO_DEPTH))
    ) else $error("cmd_fifo push while full");

    // Executor only pops a head it has been shown
    a_no_pop_empty: assert property (
        @(posedge sysclk_i) disable iff (reset_i)
        cmd_pop_i |-> cmd_valid_o
    ) else $error("cmd_fifo pop while empty");

endmodule

// ==== verilog/turf_cmd_executor.sv ====
module turf_cmd_executor #(
    parameter turf_link_pkg::word_t TRAIN_SEQUENCE = turf_link_pkg::DEFAULT_TRAIN_SEQUENCE
) (
    input  logic                   sysclk_i,
    input  logic                   reset_i,
    input  logic                   cmd_valid_i,
    input  turf_cmd_pkg::cmd_t     cmd_i,
    output logic                   cmd_pop_o,
    input  logic                   cout_train_i,
    output turf_link_pkg::nybble_t cout_o,
    output logic                   cout_frame_o
);

    import turf_link_pkg::*;
    import turf_cmd_pkg::*;

    localparam int unsigned NYB_W  = $bits(nybble_t);
    localparam int unsigned WORD_W = $bits(word_t);

    reg_data_t    regs_q [NUM_REGS];
    // Free-running frame position, 0 presents the first nybble
    frame_phase_t phase_q;
    word_t        shift_q;
    resp_t        resp;
    logic         frame_end;

    assign frame_end = (phase_q == FRAME_LAST);

    // One decision per frame, made on its last cycle
    // Forced training holds commands back in the buffer
    assign cmd_pop_o = frame_end && cmd_valid_i && !cout_train_i;

    // Response for the head command
    // Writes echo their data, reads return the stored value
    always_comb begin
        resp       = '0;
        resp.write = cmd_i.write;
        resp.index = cmd_i.index;
        resp.data  = cmd_i.write ? cmd_i.data : regs_q[cmd_i.index];
    end

    // Most significant nybble goes out first
    assign cout_o = shift_q[WORD_W-1 -: NYB_W];

    always_ff @(posedge sysclk_i) begin
        if (reset_i) begin
            phase_q      <= '0;
            shift_q      <= TRAIN_SEQUENCE;
            cout_frame_o <= 1'b0;
            for (int i = 0; i < NUM_REGS; i++) begin
                regs_q[i] <= '0;
            end
        end else begin
            phase_q      <= phase_q + 1'b1;
            // Marks the cycle that shows nybble 0 of the next frame
            cout_frame_o <= frame_end;
            if (frame_end) begin
                // Load next frame, a response or idle training
                shift_q <= cmd_pop_o ? word_t'(resp) : TRAIN_SEQUENCE;
            end else begin
                shift_q <= shift_q << NYB_W;
            end
            if (cmd_pop_o && cmd_i.write) begin
                regs_q[cmd_i.index] <= cmd_i.data;
            end
        end
    end

    // A pop closes a frame whose first nybble was marked seven cycles earlier
    a_pop_frame_edge: assert property (
        @(posedge sysclk_i) disable iff (reset_i)
        cmd_pop_o |-> $past(cout_frame_o, NYBBLES_PER_WORD - 1)
    ) else $error("cmd_executor pop outside last frame phase");

endmodule

// ==== verilog/turf_ctl_top.sv ====
module turf_ctl_top #(
    parameter turf_link_pkg::word_t TRAIN_SEQUENCE = turf_link_pkg::DEFAULT_TRAIN_SEQUENCE,
    parameter int unsigned          LOCK_COUNT     = 4,
    parameter int unsigned          FIFO_DEPTH     = 4
) (
    input  logic                   sysclk_i,
    input  logic                   reset_i,
    input  turf_link_pkg::nybble_t cin_i,
    input  logic                   cout_train_i,
    output turf_link_pkg::nybble_t cout_o,
    output logic                   cout_frame_o,
    output logic                   locked_o,
    output logic                   overflow_o
);

    import turf_cmd_pkg::*;

    // Receiver to buffer
    logic cmd_push;
    cmd_t cmd_rx;
    logic credit_return;

    // Buffer to executor
    logic cmd_valid;
    cmd_t cmd_head;
    logic cmd_pop;

    // CIN alignment, lock and command framing
    turf_cin_sync #(
        .TRAIN_SEQUENCE(TRAIN_SEQUENCE),
        .LOCK_COUNT    (LOCK_COUNT),
        .FIFO_DEPTH    (FIFO_DEPTH)
    ) u_cin_sync (
        .sysclk_i       (sysclk_i),
        .reset_i        (reset_i),
        .cin_i          (cin_i),
        .credit_return_i(credit_return),
        .cmd_push_o     (cmd_push),
        .cmd_o          (cmd_rx),
        .locked_o       (locked_o),
        .overflow_o     (overflow_o)
    );

    // Command queue, credits flow back to the receiver
    turf_cmd_fifo #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) u_cmd_fifo (
        .sysclk_i       (sysclk_i),
        .reset_i        (reset_i),
        .cmd_push_i     (cmd_push),
        .cmd_i          (cmd_rx),
        .cmd_pop_i      (cmd_pop),
        .cmd_valid_o    (cmd_valid),
        .cmd_o          (cmd_head),
        .credit_return_o(credit_return)
    );

    // Register file and COUT framing
    turf_cmd_executor #(
        .TRAIN_SEQUENCE(TRAIN_SEQUENCE)
    ) u_cmd_executor (
        .sysclk_i    (sysclk_i),
        .reset_i     (reset_i),
        .cmd_valid_i (cmd_valid),
        .cmd_i       (cmd_head),
        .cmd_pop_o   (cmd_pop),
        .cout_train_i(cout_train_i),
        .cout_o      (cout_o),
        .cout_frame_o(cout_frame_o)
    );

endmodule

// ==== sim/turf_ctl_tb.sv ====
module turf_ctl_tb;

    import turf_link_pkg::*;
    import turf_cmd_pkg::*;

    localparam int unsigned LOCK_COUNT = 4;
    localparam int unsigned FIFO_DEPTH = 4;
    localparam word_t       TRAIN      = DEFAULT_TRAIN_SEQUENCE;

    // Rough length of each test in COUT frames
    localparam int T1_FRAMES = 48;
    localparam int T2_FRAMES = 30;
    localparam int T3_FRAMES = 32;
    localparam int T4_FRAMES = 20;
    localparam int T5_FRAMES = 30;
    localparam int TIMEOUT_CYCLES =
        2 * (T1_FRAMES + T2_FRAMES + T3_FRAMES + T4_FRAMES + T5_FRAMES) * 8;

    logic    sysclk = 1'b0;
    logic    reset;
    nybble_t cin;
    logic    cout_train;
    nybble_t cout;
    logic    cout_frame;
    logic    locked;
    logic    overflow;

    // CIN bits still to send, each {word end, training word, data bit}
    logic [2:0]  bit_q [$];
    // Per queued command, whether the DUT is expected to take it
    logic        kept_q [$];
    // Falling edge from which each taken command sits in the buffer
    int          ready_q [$];
    // Responses still owed by the DUT, oldest first
    word_t       exp_q [$];
    reg_data_t   model_regs [NUM_REGS];
    logic [31:0] rng = 32'd86323;
    int          consec_train = 0;
    int          cmds_queued = 0;
    int          cmds_out = 0;
    logic        ovf_allowed = 1'b0;
    int          err_cnt = 0;
    int          test_err_base = 0;
    int          pass_cnt = 0;
    int          fail_cnt = 0;
    int          cycle_cnt = 0;
    int          frames_seen = 0;
    int          neg_cnt = 0;

    // COUT frame capture
    word_t col_word;
    int    col_cnt = 0;
    logic  resp_cur = 1'b0;
    logic  resp_next = 1'b0;
    logic  frame_chk = 1'b0;
    word_t frame_got;
    word_t frame_exp;

    always #50 sysclk = ~sysclk;

    turf_ctl_top #(
        .TRAIN_SEQUENCE(TRAIN),
        .LOCK_COUNT    (LOCK_COUNT),
        .FIFO_DEPTH    (FIFO_DEPTH)
    ) u_turf_ctl_top (
        .sysclk_i    (sysclk),
        .reset_i     (reset),
        .cin_i       (cin),
        .cout_train_i(cout_train),
        .cout_o      (cout),
        .cout_frame_o(cout_frame),
        .locked_o    (locked),
        .overflow_o  (overflow)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic note_error(input string msg);
        err_cnt++;
        $display("ERR @%0t: %s", $time, msg);
    endtask

    // Append one word, MSB first
    task automatic queue_word(input word_t w, input logic is_train);
        for (int i = 31; i >= 0; i--) begin
            bit_q.push_back({i == 0, is_train, w[i]});
        end
        if (!is_train) begin
            cmds_queued++;
        end
    endtask

    // One clock, then the next CIN nybble
    // An empty queue refills with training so word framing never slips
    task automatic tick();
        nybble_t    nyb;
        logic [2:0] b;
        @(posedge sysclk);
        nyb = '0;
        if (reset) begin
            consec_train = 0;
        end else begin
            for (int k = 0; k < 4; k++) begin
                if (bit_q.size() == 0) begin
                    queue_word(TRAIN, 1'b1);
                end
                b = bit_q.pop_front();
                nyb = {nyb[2:0], b[0]};
                if (b[2] && b[1]) begin
                    consec_train++;
                end else if (b[2]) begin
                    consec_train = 0;
                    cmds_out++;
                    // Push one cycle after this nybble, head one cycle after that
                    // so the third falling edge from here sees it buffered
                    if (kept_q.pop_front()) begin
                        ready_q.push_back(neg_cnt + 3);
                    end
                end
            end
        end
        cin <= nyb;
    endtask

    // Ten reset cycles, then idle zeros to shift the bit alignment
    task automatic apply_reset(input int offset);
        reset <= 1'b1;
        cout_train <= 1'b0;
        bit_q.delete();
        kept_q.delete();
        ready_q.delete();
        exp_q.delete();
        for (int i = 0; i < NUM_REGS; i++) begin
            model_regs[i] = '0;
        end
        ovf_allowed = 1'b0;
        cmds_queued = 0;
        cmds_out = 0;
        repeat (10) tick();
        reset <= 1'b0;
        repeat (offset) bit_q.push_back(3'b000);
    endtask

    // Queue a command; when kept, the model owes its response
    task automatic send_cmd(input logic wr, input reg_index_t idx, input reg_data_t data,
                            input logic kept);
        queue_word({wr, 4'b0000, idx, data}, 1'b0);
        kept_q.push_back(kept);
        if (kept) begin
            if (wr) begin
                model_regs[idx] = data;
            end
            // Tag byte is write flag, four zeros, index
            exp_q.push_back({wr, 4'b0000, idx, model_regs[idx]});
        end
    endtask

    task automatic send_random(input logic kept);
        rng = xorshift(rng);
        send_cmd(rng[31], rng[26:24], rng[23:0], kept);
    endtask

    // All queued commands on the wire plus the receiver pipeline
    task automatic flush_cmds();
        while (cmds_out < cmds_queued) begin
            tick();
        end
        repeat (4) tick();
    endtask

    // Two spare frames catch any response beyond the expected ones
    task automatic drain();
        while (exp_q.size() != 0) begin
            tick();
        end
        repeat (16) tick();
    endtask

    task automatic finish_test(input string name);
        if (err_cnt == test_err_base) begin
            pass_cnt++;
            $display("test %s: pass", name);
        end else begin
            fail_cnt++;
            $display("test %s: fail with %0d errors", name, err_cnt - test_err_base);
        end
        test_err_base = err_cnt;
    endtask

    // Gather 8 nybbles of each marked frame on falling edges
    // and work out what the next frame has to carry
    always @(negedge sysclk) begin
        neg_cnt++;
        frame_chk <= 1'b0;
        if (reset) begin
            col_cnt = 0;
            resp_next <= 1'b0;
        end else if (cout_frame || col_cnt > 0) begin
            if (cout_frame) begin
                col_cnt = 0;
                resp_cur = resp_next;
            end
            col_word = {col_word[27:0], cout};
            col_cnt++;
            if (col_cnt == 8) begin
                col_cnt = 0;
                frames_seen++;
                // Last nybble cycle is also the pop decision for the next frame
                if (!cout_train && ready_q.size() != 0 && ready_q[0] <= neg_cnt) begin
                    ready_q.delete(0);
                    resp_next <= 1'b1;
                end else begin
                    resp_next <= 1'b0;
                end
                frame_chk <= 1'b1;
                frame_got <= col_word;
                if (resp_cur) begin
                    frame_exp <= exp_q.pop_front();
                end else begin
                    frame_exp <= TRAIN;
                end
            end
        end
    end

    always @(posedge sysclk) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Run timed out after %0d cycles", cycle_cnt);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    a_frame_match: assert property (
        @(posedge sysclk) disable iff (reset)
        frame_chk |-> (frame_got == frame_exp)
    ) else note_error($sformatf("COUT frame %h, expected %h", frame_got, frame_exp));

    // Frames follow each other without a gap
    a_frame_period: assert property (
        @(posedge sysclk) disable iff (reset)
        frame_chk |=> cout_frame
    ) else note_error("frame marker missing right after a full frame");

    a_lock_after_training: assert property (
        @(posedge sysclk) disable iff (reset)
        $rose(locked) |-> (consec_train >= LOCK_COUNT)
    ) else note_error($sformatf("lock after only %0d training words", consec_train));

    a_overflow_expected: assert property (
        @(posedge sysclk) disable iff (reset)
        overflow |-> ovf_allowed
    ) else note_error("overflow set without credit exhaustion");

    a_reset_state: assert property (
        @(posedge sysclk)
        $fell(reset) |-> (!locked && !overflow && !cout_frame)
    ) else note_error("status outputs not clear after reset");

    initial begin
        int frames_base;
        reset <= 1'b1;
        cin <= '0;
        cout_train <= 1'b0;

        // Two training words, then a command that breaks the count
        for (int off = 0; off < 4; off++) begin
            apply_reset(off);
            queue_word(TRAIN, 1'b1);
            queue_word(TRAIN, 1'b1);
            send_cmd(1'b1, 3'd5, 24'h123456, 1'b0);
            while (!locked) begin
                tick();
            end
            repeat (16) tick();
        end
        finish_test("1 lock at offsets 0 to 3");

        // Reads of every register, then writes, then reads again
        for (int i = 0; i < NUM_REGS; i++) begin
            rng = xorshift(rng);
            send_cmd(1'b0, reg_index_t'(i), rng[23:0], 1'b1);
        end
        for (int i = 0; i < NUM_REGS; i++) begin
            rng = xorshift(rng);
            send_cmd(1'b1, reg_index_t'(i), rng[23:0], 1'b1);
        end
        for (int i = 0; i < NUM_REGS; i++) begin
            send_cmd(1'b0, reg_index_t'(i), 24'h000000, 1'b1);
        end
        drain();
        finish_test("2 register reset and write-read");

        // Idle link
        frames_base = frames_seen;
        repeat (6 * 8) tick();
        assert (frames_seen - frames_base >= 5)
            else note_error($sformatf("%0d idle frames seen", frames_seen - frames_base));
        // Forced training holds two commands back
        cout_train <= 1'b1;
        send_cmd(1'b1, 3'd2, 24'h3C5A96, 1'b1);
        send_cmd(1'b0, 3'd2, 24'h000000, 1'b1);
        flush_cmds();
        repeat (4 * 8) tick();
        cout_train <= 1'b0;
        drain();
        // Training words in between give no responses
        for (int i = 0; i < 3; i++) begin
            send_random(1'b1);
            queue_word(TRAIN, 1'b1);
            queue_word(TRAIN, 1'b1);
        end
        drain();
        finish_test("3 training frames");

        // Back-pressure, only FIFO_DEPTH credits exist
        cout_train <= 1'b1;
        repeat (8) tick();
        ovf_allowed = 1'b1;
        for (int k = 0; k < FIFO_DEPTH + 3; k++) begin
            send_random(k < FIFO_DEPTH);
        end
        flush_cmds();
        assert (overflow) else note_error("overflow not set after dropped commands");
        cout_train <= 1'b0;
        drain();
        assert (overflow) else note_error("overflow cleared before reset");
        finish_test("4 back-pressure");

        for (int k = 0; k < 24; k++) begin
            send_random(1'b1);
        end
        drain();
        finish_test("5 random reads and writes");

        $display("Tests: %0d passed, %0d failed, %0d errors", pass_cnt, fail_cnt, err_cnt);
        if (err_cnt == 0 && fail_cnt == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
verilog/turf_link_pkg.sv
verilog/turf_cmd_pkg.sv
verilog/turf_cin_sync.sv
verilog/turf_cmd_fifo.sv
verilog/turf_cmd_executor.sv
verilog/turf_ctl_top.sv
sim/turf_ctl_tb.sv

// ==== Bender.yml ====
package:
  name: turf_ctl

sources:
  - files:
      - verilog/turf_link_pkg.sv
      - verilog/turf_cmd_pkg.sv
      - verilog/turf_cin_sync.sv
      - verilog/turf_cmd_fifo.sv
      - verilog/turf_cmd_executor.sv
      - verilog/turf_ctl_top.sv
  - target: test
    files:
      - sim/turf_ctl_tb.sv
